/* dv/surfaceGolden.txt */
// Ray count, then per ray: pixelX pixelY clearColor / origin x y z / dir x y z
// Hit table: count, then per hit: prim t color normalX normalY normalZ type
// Leaf reports: count, then per report: start0 count0 start1 count1
// Expected: hit prim color hitPosX hitPosY hitPosZ
4
// Ray 0, nearest hit sits in a leaf group
001 002 102030
00000000 00000000 00000000
00000000 00000000 00010000
3
001 00080000 80ff40 00000000 00000000 ffff0000 1
00a 00030000 2040c0 00000000 00010000 00000000 2
015 00050000 ffffff 00010000 00000000 00000000 1
2
008 05 000 00
014 02 01e 04
1 00a 2040c0 00000000 00000000 00030000
// Ray 1, ground hit in a dark checker cell, held by outFull
010 004 000000
00010000 00040000 00020000
00008000 ffffc000 00010000
2
000 00100000 c88040 00000000 00010000 00000000 3
002 00200000 ffffff 00000000 00010000 00000000 1
1
028 03 02c 01
1 000 644020 00090000 00000000 00120000
// Ray 2, ground hit in a light cell, product rounds toward minus infinity
011 004 000000
00000000 00020000 00000000
ffff4000 ffffe000 00010000
2
000 00100001 60a0e0 00000000 00010000 00000000 3
001 00300000 808080 00010000 00000000 00000000 1
0
1 000 60a0e0 fff3ffff ffffffff 00100001
// Ray 3, misses everything, empty leaf slot skipped
007 009 0a0b0c
00000000 00000000 00000000
00000000 00000000 00010000
0
1
010 00 018 06
0 fff 0a0b0c 00000000 00000000 00000000

/* tb.f */
verilog/surfacePkg.sv
verilog/groupQueueIf.sv
verilog/primitiveGroupQueue.sv
verilog/batchScheduler.sv
verilog/closestHitTracker.sv
verilog/surfaceShading.sv
verilog/surfaceUnit.sv
dv/tbClock.sv
dv/surfaceTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the surface unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 --top-module surfaceTb -f tb.f -o surfaceSim \
    && ./obj_dir/surfaceSim > sim.log 2>&1 \
    || echo "Simulation build or run returned an error"

cat sim.log 2>/dev/null
grep -q "test passed" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

/* dv/surfaceTb.sv */
`timescale 1ns/1ns

module surfaceTb;
    import surfacePkg::*;

    localparam int TEST_UNIT = 4;
    localparam int GLOBAL_START = 0;
    localparam int GLOBAL_COUNT = 3;
    localparam int TIMEOUT = 2000;
    localparam int MAX_RAYS = 16;
    // Ray that is held in done while the next one waits
    localparam int STALL_RAY = 1;

    logic clk;
    logic resetn;
    logic rayValid;
    vec3T rayOrigin;
    vec3T rayDir;
    logic [9:0] pixelX;
    logic [9:0] pixelY;
    rgb8T clearColor;
    logic traversalDone;
    logic leafValid;
    primIndexT leafStart0;
    primIndexT leafStart1;
    primCountT leafCount0;
    primCountT leafCount1;
    logic outFull;
    logic candHit;
    fixedT candT;
    primIndexT candPrim;
    rgb8T candColor;
    vec3T candNormal;
    surfaceTypeT candType;
    logic rayFull;
    logic traverseStart;
    logic traverseRestart;
    logic outValid;
    primIndexT startPrimitive;
    primIndexT endPrimitive;
    logic outHit;
    vec3T outHitPos;
    vec3T outNormal;
    rgb8T outColor;
    primIndexT outPrim;
    surfaceTypeT outType;
    logic [9:0] outX;
    logic [9:0] outY;

    logic [31:0] goldenMem [0:511];
    int numRays;
    int rayBase [MAX_RAYS];
    int hitBase [MAX_RAYS];
    int numHits [MAX_RAYS];
    int leafBase [MAX_RAYS];
    int numLeaves [MAX_RAYS];
    int expBase [MAX_RAYS];
    int groupStarts [$];
    int groupCounts [$];
    int coverCount [0:4095];
    int outCount;
    integer seed;

    tbClock #(.PERIOD(40)) clockGen (.clk(clk));

    surfaceUnit #(
        .TEST_UNIT(TEST_UNIT),
        .QUEUE_DEPTH(8),
        .GLOBAL_START(primIndexT'(GLOBAL_START)),
        .GLOBAL_COUNT(primCountT'(GLOBAL_COUNT))
    ) i_surfaceUnit (.*);

    // --------------------------------------------------
    // Reporting
    // --------------------------------------------------

    task automatic stopRun();
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            stopRun();
        end
    endtask

    task automatic timedOut(input string what);
        $display("Timeout after %0d cycles: %s", TIMEOUT, what);
        stopRun();
    endtask

    // Word offsets of every record in the golden image
    task automatic indexGolden();
        int p;
        p = 1;
        numRays = int'(goldenMem[0]);
        for (int r = 0; r < numRays; r++) begin
            rayBase[r] = p;
            p = p + 9;
            numHits[r] = int'(goldenMem[p]);
            hitBase[r] = p + 1;
            p = p + 1 + 7 * numHits[r];
            numLeaves[r] = int'(goldenMem[p]);
            leafBase[r] = p + 1;
            p = p + 1 + 4 * numLeaves[r];
            expBase[r] = p;
            p = p + 6;
        end
    endtask

    task automatic checkResetOutputs();
        checkValue("outValid", 32'(outValid), 32'd0);
        checkValue("rayFull", 32'(rayFull), 32'd0);
        checkValue("traverseStart", 32'(traverseStart), 32'd0);
        checkValue("traverseRestart", 32'(traverseRestart), 32'd0);
        checkValue("startPrimitive", 32'(startPrimitive), 32'(NULL_PRIM));
        checkValue("endPrimitive", 32'(endPrimitive), 32'(NULL_PRIM));
    endtask

    // --------------------------------------------------
    // External tester and batch bookkeeping
    // --------------------------------------------------

    function automatic int batchEnd();
        int hi;
        hi = int'(startPrimitive) + TEST_UNIT;
        if (int'(endPrimitive) < hi) begin
            hi = int'(endPrimitive);
        end
        return hi;
    endfunction

    task automatic driveTester(input int r);
        int lo;
        int hi;
        int idx;
        int best;
        lo = int'(startPrimitive);
        hi = batchEnd();
        best = -1;
        if (startPrimitive != endPrimitive) begin
            for (int h = 0; h < numHits[r]; h++) begin
                idx = hitBase[r] + 7 * h;
                if (int'(goldenMem[idx]) >= lo && int'(goldenMem[idx]) < hi) begin
                    if (best < 0
                            || fixedT'(goldenMem[idx + 1]) < fixedT'(goldenMem[best + 1])) begin
                        best = idx;
                    end
                end
            end
        end
        candHit = (best >= 0);
        if (best >= 0) begin
            candPrim = primIndexT'(goldenMem[best]);
            candT = fixedT'(goldenMem[best + 1]);
            candColor = rgb8T'(goldenMem[best + 2][23:0]);
            candNormal.x = fixedT'(goldenMem[best + 3]);
            candNormal.y = fixedT'(goldenMem[best + 4]);
            candNormal.z = fixedT'(goldenMem[best + 5]);
            candType = surfaceTypeT'(goldenMem[best + 6][1:0]);
        end
    endtask

    task automatic recordBatch();
        int lo;
        int hi;
        logic found;
        lo = int'(startPrimitive);
        hi = batchEnd();
        found = 1'b0;
        if (startPrimitive != endPrimitive && lo < hi) begin
            for (int g = 0; g < groupStarts.size(); g++) begin
                if (groupStarts[g] + groupCounts[g] == int'(endPrimitive)
                        && lo >= groupStarts[g]) begin
                    found = 1'b1;
                    checkValue("startPrimitive step",
                               32'((lo - groupStarts[g]) % TEST_UNIT), 32'd0);
                end
            end
            if (!found) begin
                $display("Batch %0d..%0d lies outside every queued group", lo, hi - 1);
                stopRun();
            end
            for (int i = lo; i < hi; i++) begin
                coverCount[i] = coverCount[i] + 1;
            end
        end
    endtask

    task automatic stepEdge(input int r);
        @(negedge clk);
        if (outValid) begin
            outCount = outCount + 1;
        end
        recordBatch();
        driveTester(r);
    endtask

    // --------------------------------------------------
    // Per ray checks
    // --------------------------------------------------

    task automatic checkRecord(input int r);
        int eb;
        int hb;
        eb = expBase[r];
        hb = -1;
        checkValue("outX", 32'(outX), goldenMem[rayBase[r]]);
        checkValue("outY", 32'(outY), goldenMem[rayBase[r] + 1]);
        checkValue("outHit", 32'(outHit), goldenMem[eb]);
        checkValue("outColor", 32'(outColor), goldenMem[eb + 2]);
        if (goldenMem[eb][0]) begin
            for (int h = 0; h < numHits[r]; h++) begin
                if (goldenMem[hitBase[r] + 7 * h] == goldenMem[eb + 1]) begin
                    hb = hitBase[r] + 7 * h;
                end
            end
            if (hb < 0) begin
                $display("Golden record of ray %0d names a primitive outside its table", r);
                stopRun();
            end
            checkValue("outPrim", 32'(outPrim), goldenMem[eb + 1]);
            checkValue("outType", 32'(outType), goldenMem[hb + 6]);
            checkValue("outNormal.x", 32'(outNormal.x), goldenMem[hb + 3]);
            checkValue("outNormal.y", 32'(outNormal.y), goldenMem[hb + 4]);
            checkValue("outNormal.z", 32'(outNormal.z), goldenMem[hb + 5]);
            checkValue("outHitPos.x", 32'(outHitPos.x), goldenMem[eb + 3]);
            checkValue("outHitPos.y", 32'(outHitPos.y), goldenMem[eb + 4]);
            checkValue("outHitPos.z", 32'(outHitPos.z), goldenMem[eb + 5]);
        end else begin
            checkValue("outType", 32'(outType), 32'(stNone));
        end
        for (int g = 0; g < groupStarts.size(); g++) begin
            for (int i = groupStarts[g]; i < groupStarts[g] + groupCounts[g]; i++) begin
                checkValue("batch coverage", 32'(coverCount[i]), 32'd1);
            end
        end
    endtask

    task automatic processRay(input int r);
        int lb;
        int stall;
        int held;
        int waited;
        groupStarts.delete();
        groupCounts.delete();
        groupStarts.push_back(GLOBAL_START);
        groupCounts.push_back(GLOBAL_COUNT);
        for (int k = 0; k < numLeaves[r]; k++) begin
            lb = leafBase[r] + 4 * k;
            if (goldenMem[lb + 1] != 0) begin
                groupStarts.push_back(int'(goldenMem[lb]));
                groupCounts.push_back(int'(goldenMem[lb + 1]));
            end
            if (goldenMem[lb + 3] != 0) begin
                groupStarts.push_back(int'(goldenMem[lb + 2]));
                groupCounts.push_back(int'(goldenMem[lb + 3]));
            end
        end
        foreach (coverCount[i]) begin
            coverCount[i] = 0;
        end
        clearColor = rgb8T'(goldenMem[rayBase[r] + 2][23:0]);
        stall = (r == STALL_RAY) ? 40 : ($random(seed) & 7);
        outFull = (stall > 0);

        waited = 0;
        do begin
            stepEdge(r);
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                timedOut("traverseStart never pulsed");
            end
        end while (!traverseStart);

        // One BVH leaf report per cycle
        for (int k = 0; k < numLeaves[r]; k++) begin
            lb = leafBase[r] + 4 * k;
            leafValid = 1'b1;
            leafStart0 = primIndexT'(goldenMem[lb]);
            leafCount0 = primCountT'(goldenMem[lb + 1]);
            leafStart1 = primIndexT'(goldenMem[lb + 2]);
            leafCount1 = primCountT'(goldenMem[lb + 3]);
            stepEdge(r);
        end
        leafValid = 1'b0;
        traversalDone = 1'b1;

        waited = 0;
        held = 0;
        do begin
            if (outFull) begin
                if (held >= stall) begin
                    if (r == STALL_RAY && r < numRays - 1) begin
                        checkValue("rayFull", 32'(rayFull), 32'd1);
                    end
                    outFull = 1'b0;
                end
                held = held + 1;
            end
            stepEdge(r);
            if (outFull) begin
                checkValue("outValid", 32'(outValid), 32'd0);
            end
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                timedOut("traverseRestart never pulsed");
            end
        end while (!traverseRestart);
        traversalDone = 1'b0;
        checkValue("outValid", 32'(outValid), 32'd1);
        checkValue("output count", 32'(outCount), 32'(r + 1));
        checkRecord(r);
    endtask

    task automatic sendRays();
        int rb;
        int waited;
        for (int r = 0; r < numRays; r++) begin
            rb = rayBase[r];
            waited = 0;
            do begin
                @(negedge clk);
                waited = waited + 1;
                if (waited > TIMEOUT) begin
                    timedOut("input buffer never freed");
                end
            end while (rayFull);
            rayValid = 1'b1;
            pixelX = 10'(goldenMem[rb]);
            pixelY = 10'(goldenMem[rb + 1]);
            rayOrigin.x = fixedT'(goldenMem[rb + 3]);
            rayOrigin.y = fixedT'(goldenMem[rb + 4]);
            rayOrigin.z = fixedT'(goldenMem[rb + 5]);
            rayDir.x = fixedT'(goldenMem[rb + 6]);
            rayDir.y = fixedT'(goldenMem[rb + 7]);
            rayDir.z = fixedT'(goldenMem[rb + 8]);
            @(negedge clk);
            rayValid = 1'b0;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        seed = 32'h04afd7ab;
        outCount = 0;
        resetn = 1'b0;
        rayValid = 1'b0;
        rayOrigin = '0;
        rayDir = '0;
        pixelX = '0;
        pixelY = '0;
        clearColor = '0;
        traversalDone = 1'b0;
        leafValid = 1'b0;
        leafStart0 = '0;
        leafStart1 = '0;
        leafCount0 = '0;
        leafCount1 = '0;
        outFull = 1'b0;
        candHit = 1'b0;
        candT = '0;
        candPrim = '0;
        candColor = '0;
        candNormal = '0;
        candType = stNone;
        $readmemh("dv/surfaceGolden.txt", goldenMem);
        indexGolden();

        repeat (10) begin
            @(negedge clk);
            checkResetOutputs();
        end
        resetn = 1'b1;
        @(negedge clk);
        checkResetOutputs();

        fork
            sendRays();
            begin
                for (int r = 0; r < numRays; r++) begin
                    processRay(r);
                end
            end
        join

        // Quiet window after the last ray, no further record may appear
        repeat (20) begin
            stepEdge(numRays - 1);
        end
        checkValue("output count", 32'(outCount), 32'(numRays));
        $display("test passed");
        $finish;
    end
endmodule

/* dv/tbClock.sv */
`timescale 1ns/1ns

// Free running testbench clock
module tbClock #(
    parameter int PERIOD = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end
endmodule

/* verilog/surfaceUnit.sv */
`timescale 1ns/1ns

module surfaceUnit #(
    parameter int TEST_UNIT = 4,
    parameter int QUEUE_DEPTH = 8,
    parameter surfacePkg::primIndexT GLOBAL_START = '0,
    parameter surfacePkg::primCountT GLOBAL_COUNT = 8'd3
) (
    input  logic clk,
    input  logic resetn,
    input  logic rayValid,
    input  surfacePkg::vec3T rayOrigin,
    input  surfacePkg::vec3T rayDir,
    input  logic [9:0] pixelX,
    input  logic [9:0] pixelY,
    input  surfacePkg::rgb8T clearColor,
    input  logic traversalDone,
    input  logic leafValid,
    input  surfacePkg::primIndexT leafStart0,
    input  surfacePkg::primIndexT leafStart1,
    input  surfacePkg::primCountT leafCount0,
    input  surfacePkg::primCountT leafCount1,
    input  logic outFull,
    input  logic candHit,
    input  surfacePkg::fixedT candT,
    input  surfacePkg::primIndexT candPrim,
    input  surfacePkg::rgb8T candColor,
    input  surfacePkg::vec3T candNormal,
    input  surfacePkg::surfaceTypeT candType,
    output logic rayFull,
    output logic traverseStart,
    output logic traverseRestart,
    output logic outValid,
    output surfacePkg::primIndexT startPrimitive,
    output surfacePkg::primIndexT endPrimitive,
    output logic outHit,
    output surfacePkg::vec3T outHitPos,
    output surfacePkg::vec3T outNormal,
    output surfacePkg::rgb8T outColor,
    output surfacePkg::primIndexT outPrim,
    output surfacePkg::surfaceTypeT outType,
    output logic [9:0] outX,
    output logic [9:0] outY
);
    import surfacePkg::*;

    logic done;
    vec3T curOrigin;
    vec3T curDir;
    logic [9:0] curX;
    logic [9:0] curY;
    primIndexT leafStarts [2];
    primCountT leafCounts [2];

    assign leafStarts[0] = leafStart0;
    assign leafStarts[1] = leafStart1;
    assign leafCounts[0] = leafCount0;
    assign leafCounts[1] = leafCount1;

    groupQueueIf gq ();
    closestHitIf chIf ();

    batchScheduler #(.TEST_UNIT(TEST_UNIT)) scheduler (
        .clk(clk), .resetn(resetn), .rayValid(rayValid), .traversalDone(traversalDone),
        .outFull(outFull), .leafValid(leafValid), .rayOrigin(rayOrigin), .rayDir(rayDir),
        .pixelX(pixelX), .pixelY(pixelY), .rayFull(rayFull), .traverseStart(traverseStart),
        .traverseRestart(traverseRestart), .outValid(outValid), .done(done),
        .curOrigin(curOrigin), .curDir(curDir), .curX(curX), .curY(curY),
        .startPrimitive(startPrimitive), .endPrimitive(endPrimitive), .q(gq)
    );

    primitiveGroupQueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .globalStart(GLOBAL_START),
        .globalCount(GLOBAL_COUNT)
    ) groupQueue (
        .clk(clk), .resetn(resetn), .q(gq), .leafStart(leafStarts), .leafCount(leafCounts)
    );

    // Tracker restarts together with the queue on each new ray
    closestHitTracker tracker (
        .clk(clk), .resetn(resetn), .clear(gq.clear), .clearColor(clearColor),
        .candHit(candHit), .candT(candT), .candPrim(candPrim), .candColor(candColor),
        .candNormal(candNormal), .candType(candType), .ch(chIf)
    );

    surfaceShading shading (
        .clk(clk), .resetn(resetn), .done(done), .ch(chIf), .curOrigin(curOrigin),
        .curDir(curDir), .curX(curX), .curY(curY), .outHit(outHit), .outHitPos(outHitPos),
        .outNormal(outNormal), .outColor(outColor), .outPrim(outPrim), .outType(outType),
        .outX(outX), .outY(outY)
    );
endmodule

/* verilog/surfaceShading.sv */
`timescale 1ns/1ns

module surfaceShading (
    input  logic clk,
    input  logic resetn,
    input  logic done,
    closestHitIf.shading ch,
    input  surfacePkg::vec3T curOrigin,
    input  surfacePkg::vec3T curDir,
    input  logic [9:0] curX,
    input  logic [9:0] curY,
    output logic outHit,
    output surfacePkg::vec3T outHitPos,
    output surfacePkg::vec3T outNormal,
    output surfacePkg::rgb8T outColor,
    output surfacePkg::primIndexT outPrim,
    output surfacePkg::surfaceTypeT outType,
    output logic [9:0] outX,
    output logic [9:0] outY
);
    import surfacePkg::*;

    vec3T hitPos;
    rgb8T shadedColor;
    logic darkCell;

    // origin + t * dir on one axis
    function automatic fixedT scaleAdd(input fixedT o, input fixedT t, input fixedT d);
        logic signed [63:0] prod;
        prod = 64'(t) * 64'(d);
        return o + fixedT'(prod >>> FRAC_WIDTH);
    endfunction

    assign hitPos.x = scaleAdd(curOrigin.x, ch.t, curDir.x);
    assign hitPos.y = scaleAdd(curOrigin.y, ch.t, curDir.y);
    assign hitPos.z = scaleAdd(curOrigin.z, ch.t, curDir.z);

    // --------------------------------------------------
    // Checker texture on the ground
    // --------------------------------------------------

    assign darkCell = ch.hit && (ch.prim == GROUND_PRIM)
        && (hitPos.x[CHECKER_SHIFT] != hitPos.z[CHECKER_SHIFT]);

    always_comb begin
        shadedColor = ch.color;
        if (darkCell) begin
            shadedColor.r = ch.color.r >> 1;
            shadedColor.g = ch.color.g >> 1;
            shadedColor.b = ch.color.b >> 1;
        end
    end

    // Output record
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            outHit <= 1'b0;
            outType <= stNone;
        end else if (done) begin
            outHit <= ch.hit;
            outType <= ch.surfType;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            outHitPos <= hitPos;
            outNormal <= ch.normal;
            outColor <= shadedColor;
            outPrim <= ch.prim;
            outX <= curX;
            outY <= curY;
        end
    end
endmodule

/* verilog/closestHitTracker.sv */
`timescale 1ns/1ns

module closestHitTracker (
    input  logic clk,
    input  logic resetn,
    input  logic clear,
    input  surfacePkg::rgb8T clearColor,
    input  logic candHit,
    input  surfacePkg::fixedT candT,
    input  surfacePkg::primIndexT candPrim,
    input  surfacePkg::rgb8T candColor,
    input  surfacePkg::vec3T candNormal,
    input  surfacePkg::surfaceTypeT candType,
    closestHitIf.tracker ch
);
    import surfacePkg::*;

    logic isCloser;

    // Strictly nearer wins, so an earlier equal hit stays
    assign isCloser = candHit && (candT < ch.t);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ch.hit <= 1'b0;
            ch.surfType <= stNone;
        end else if (clear) begin
            ch.hit <= 1'b0;
            ch.surfType <= stNone;
        end else if (isCloser) begin
            ch.hit <= 1'b1;
            ch.surfType <= candType;
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            ch.t <= FIXED_MAX;
            ch.prim <= NULL_PRIM;
            // Background colour for rays that miss everything
            ch.color <= clearColor;
        end else if (isCloser) begin
            ch.t <= candT;
            ch.prim <= candPrim;
            ch.color <= candColor;
            ch.normal <= candNormal;
        end
    end
endmodule

/* verilog/batchScheduler.sv */
`timescale 1ns/1ns

module batchScheduler #(
    parameter int TEST_UNIT = 4
) (
    input  logic clk,
    input  logic resetn,
    input  logic rayValid,
    input  logic traversalDone,
    input  logic outFull,
    input  logic leafValid,
    input  surfacePkg::vec3T rayOrigin,
    input  surfacePkg::vec3T rayDir,
    input  logic [9:0] pixelX,
    input  logic [9:0] pixelY,
    output logic rayFull,
    output logic traverseStart,
    output logic traverseRestart,
    output logic outValid,
    output logic done,
    output surfacePkg::vec3T curOrigin,
    output surfacePkg::vec3T curDir,
    output logic [9:0] curX,
    output logic [9:0] curY,
    output surfacePkg::primIndexT startPrimitive,
    output surfacePkg::primIndexT endPrimitive,
    groupQueueIf.scheduler q
);
    import surfacePkg::*;

    typedef enum logic [1:0] {
        sInit,
        sSurfacing,
        sDone
    } stateT;

    // Group counts are padded up to whole test units
    localparam logic [COUNT_WIDTH:0] UNIT_MASK = (COUNT_WIDTH + 1)'(TEST_UNIT - 1);
    localparam primIndexT UNIT_STEP = PRIM_INDEX_WIDTH'(TEST_UNIT);

    stateT state;
    primIndexT startIdx;
    primIndexT alignedEnd;
    primIndexT realEnd;
    logic batchPending;
    logic takeRay;
    logic enteringDone;
    logic [COUNT_WIDTH:0] alignedCount;

    // One-entry input buffer
    vec3T bufOrigin;
    vec3T bufDir;
    logic [9:0] bufX;
    logic [9:0] bufY;

    assign batchPending = (startIdx != alignedEnd);
    assign takeRay = (state == sInit) && rayFull;
    assign enteringDone = (state == sSurfacing) && !batchPending && q.empty && traversalDone;
    assign done = (state == sDone) || enteringDone;
    assign alignedCount = ((COUNT_WIDTH + 1)'(q.headCount) + UNIT_MASK) & ~UNIT_MASK;

    // --------------------------------------------------
    // Queue control
    // --------------------------------------------------

    assign q.clear = takeRay;
    assign q.leafValid = leafValid && (state == sSurfacing);
    assign q.pop = (state == sSurfacing) && !batchPending && !q.empty;

    assign startPrimitive = startIdx;
    assign endPrimitive = realEnd;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rayFull <= 1'b0;
        end else if (rayValid && !rayFull) begin
            rayFull <= 1'b1;
        end else if (takeRay) begin
            rayFull <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rayValid && !rayFull) begin
            bufOrigin <= rayOrigin;
            bufDir <= rayDir;
            bufX <= pixelX;
            bufY <= pixelY;
        end
        if (takeRay) begin
            curOrigin <= bufOrigin;
            curDir <= bufDir;
            curX <= bufX;
            curY <= bufY;
        end
    end

    // --------------------------------------------------
    // Surfacing FSM
    // --------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= sInit;
            traverseStart <= 1'b0;
            traverseRestart <= 1'b0;
            outValid <= 1'b0;
            startIdx <= NULL_PRIM;
            alignedEnd <= NULL_PRIM;
            realEnd <= NULL_PRIM;
        end else begin
            traverseStart <= 1'b0;
            traverseRestart <= 1'b0;
            outValid <= 1'b0;
            case (state)
                sInit: begin
                    if (takeRay) begin
                        traverseStart <= 1'b1;
                        state <= sSurfacing;
                    end
                end
                sSurfacing: begin
                    if (batchPending) begin
                        startIdx <= startIdx + UNIT_STEP;
                    end else if (!q.empty) begin
                        // Next group from the head of the queue
                        startIdx <= q.headStart;
                        realEnd <= q.headStart + primIndexT'(q.headCount);
                        alignedEnd <= q.headStart + primIndexT'(alignedCount);
                    end else if (traversalDone) begin
                        startIdx <= NULL_PRIM;
                        alignedEnd <= NULL_PRIM;
                        realEnd <= NULL_PRIM;
                        state <= sDone;
                    end
                end
                sDone: begin
                    // Hold the record while downstream is full
                    if (!outFull) begin
                        outValid <= 1'b1;
                        traverseRestart <= 1'b1;
                        state <= sInit;
                    end
                end
                default: begin
                    state <= sInit;
                end
            endcase
        end
    end
endmodule

/* verilog/primitiveGroupQueue.sv */
`timescale 1ns/1ns

module primitiveGroupQueue #(
    parameter int QUEUE_DEPTH = 8,
    parameter surfacePkg::primIndexT globalStart = '0,
    parameter surfacePkg::primCountT globalCount = 8'd3
) (
    input  logic clk,
    input  logic resetn,
    groupQueueIf.queue q,
    input  surfacePkg::primIndexT leafStart [2],
    input  surfacePkg::primCountT leafCount [2]
);
    import surfacePkg::*;

    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

    primIndexT startMem [QUEUE_DEPTH];
    primCountT countMem [QUEUE_DEPTH];

    logic [PTR_WIDTH-1:0] head;
    logic [PTR_WIDTH-1:0] tail;
    logic [PTR_WIDTH-1:0] slot1;
    logic push0;
    logic push1;

    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] p);
        return (p == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Empty leaf slots are skipped, slot 0 goes first
    assign push0 = q.leafValid && (leafCount[0] != '0);
    assign push1 = q.leafValid && (leafCount[1] != '0);
    assign slot1 = push0 ? nextPtr(tail) : tail;

    assign q.empty = (head == tail);
    assign q.headStart = startMem[head];
    assign q.headCount = countMem[head];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            head <= '0;
            tail <= '0;
        end else if (q.clear) begin
            // Global group sits in slot 0
            head <= '0;
            tail <= nextPtr('0);
        end else begin
            if (q.pop) begin
                head <= nextPtr(head);
            end
            tail <= push1 ? nextPtr(slot1) : slot1;
        end
    end

    always_ff @(posedge clk) begin
        if (q.clear) begin
            startMem[0] <= globalStart;
            countMem[0] <= globalCount;
        end else begin
            if (push0) begin
                startMem[tail] <= leafStart[0];
                countMem[tail] <= leafCount[0];
            end
            if (push1) begin
                startMem[slot1] <= leafStart[1];
                countMem[slot1] <= leafCount[1];
            end
        end
    end
endmodule

/* verilog/groupQueueIf.sv */
`timescale 1ns/1ns

// Scheduler to primitive group queue
interface groupQueueIf;
    import surfacePkg::*;

    logic clear;
    logic leafValid;
    logic pop;
    logic empty;
    primIndexT headStart;
    primCountT headCount;

    modport scheduler (
        output clear,
        output leafValid,
        output pop,
        input  empty,
        input  headStart,
        input  headCount
    );

    modport queue (
        input  clear,
        input  leafValid,
        input  pop,
        output empty,
        output headStart,
        output headCount
    );
endinterface

// Closest hit record, tracker to shading
interface closestHitIf;
    import surfacePkg::*;

    logic hit;
    fixedT t;
    primIndexT prim;
    rgb8T color;
    vec3T normal;
    surfaceTypeT surfType;

    modport tracker (
        output hit,
        output t,
        output prim,
        output color,
        output normal,
        output surfType
    );

    modport shading (
        input hit,
        input t,
        input prim,
        input color,
        input normal,
        input surfType
    );
endinterface

/* verilog/surfacePkg.sv */
package surfacePkg;

    // --------------------------------------------------
    // Fixed point and vectors
    // --------------------------------------------------

    // Q16.16 values
    localparam int FRAC_WIDTH = 16;

    typedef logic signed [31:0] fixedT;

    typedef struct packed {
        fixedT x;
        fixedT y;
        fixedT z;
    } vec3T;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8T;

    // Largest positive distance, i.e. no hit yet
    localparam fixedT FIXED_MAX = 32'h7fff_ffff;

    // --------------------------------------------------
    // Primitive indexing
    // --------------------------------------------------

    localparam int PRIM_INDEX_WIDTH = 12;
    localparam int COUNT_WIDTH = 8;

    typedef logic [PRIM_INDEX_WIDTH-1:0] primIndexT;
    typedef logic [COUNT_WIDTH-1:0] primCountT;

    // Batch bounds while no batch is active
    localparam primIndexT NULL_PRIM = '1;

    typedef enum logic [1:0] {
        stNone,
        stDiffuse,
        stMirror,
        stGround
    } surfaceTypeT;

    // --------------------------------------------------
    // Ground texture
    // --------------------------------------------------

    // First global primitive is the ground plane
    localparam primIndexT GROUND_PRIM = 12'd0;

    // Checker cell of 16 units along x and z
    localparam int CHECKER_SHIFT = FRAC_WIDTH + 4;

endpackage
